// ==== Makefile ====
# Verilator build and run for the uart tx protocol engine

VERILATOR ?= verilator
TOP       ?= uart_pe_tx_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIMFLAGS  ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIMFLAGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
logic/uart_tx_pkg.sv
logic/tx_bit_timer.sv
logic/tx_word_loader.sv
logic/tx_frame_fsm.sv
logic/tx_line_driver.sv
logic/uart_pe_tx.sv
sim/uart_pe_tx_properties.sv
sim/uart_pe_tx_tb.sv

// ==== logic/tx_bit_timer.sv ====
//==================================================
// uart tx bit timer
// divider counter nested in an oversampling counter
// bit_end marks the last cycle of every bit time
//==================================================

`timescale 1ns/10ps

module tx_bit_timer
#(
	parameter int clkdiv_w = 12,
	parameter int os_w     = 4
)
(
	input  logic                  pe_clk,
	input  logic                  pe_rstn,
	input  uart_tx_pkg::tx_state_e state,
	input  logic [clkdiv_w-1:0]   clkdiv,
	input  logic [os_w-1:0]       oversampling,
	output logic                  bit_end
);

	logic [clkdiv_w-1:0] div_cnt;
	logic [os_w-1:0] os_cnt;
	logic active;
	logic div_end;
	logic os_end;

	// only frame phases carry a bit time
	assign active = state inside {uart_tx_pkg::tx_start, uart_tx_pkg::tx_data,
		uart_tx_pkg::tx_parity, uart_tx_pkg::tx_stop, uart_tx_pkg::tx_interval};

	assign div_end = (div_cnt == clkdiv - 1'b1);
	assign os_end  = (os_cnt == oversampling - 1'b1);
	// last divider tick of last oversampling point
	assign bit_end = div_end && os_end;

	//==================================================
	// counters
	//==================================================

	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
		begin
			div_cnt <= '0;
			os_cnt  <= '0;
		end
		else if (!active)
		begin
			// held at zero so a new start is aligned
			div_cnt <= '0;
			os_cnt  <= '0;
		end
		else if (div_end)
		begin
			div_cnt <= '0;
			// os steps once per divider wrap
			os_cnt  <= os_end ? '0 : os_cnt + 1'b1;
		end
		else
		begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

endmodule

// ==== logic/tx_frame_fsm.sv ====
//==================================================
// uart tx frame sequencer
// one-hot phase register with a shared slot counter
// for data, stop and interval bits
// announces each slot the line is about to enter
//==================================================

`timescale 1ns/10ps

module tx_frame_fsm
#(
	parameter int fifo_lvl_w = 5
)
(
	input  logic                       pe_clk,
	input  logic                       pe_rstn,
	input  logic                       pe_tx_enable,
	input  logic                       pe_tx_logic_clr,
	input  logic                       bit_end,
	input  logic [fifo_lvl_w-1:0]      fifo_level,
	input  uart_tx_pkg::tx_frame_cfg_t cfg,
	output uart_tx_pkg::tx_state_e     state,
	output uart_tx_pkg::tx_slot_t      slot,
	output logic                       slot_load,
	output logic                       frame_end
);

	uart_tx_pkg::tx_state_e state_nxt;
	uart_tx_pkg::tx_state_e after_frame;
	logic [3:0] cnt;
	logic [3:0] cnt_nxt;
	logic [3:0] data_last;
	logic [3:0] stop_last;
	logic [3:0] interval_last;

	// last index of each counted phase
	assign data_last     = uart_tx_pkg::data_width(cfg) - 4'd1;
	assign stop_last     = {2'b00, uart_tx_pkg::stop_width(cfg)} - 4'd1;
	assign interval_last = cfg.interval_bit - 4'd1;

	// back to back while words remain, else wind down
	always_comb
	begin
		if (fifo_level == '0)
			after_frame = uart_tx_pkg::tx_end;
		else
			after_frame = uart_tx_pkg::tx_start;
	end

	//==================================================
	// next phase and slot counter
	//==================================================

	always_comb
	begin
		state_nxt = state;
		cnt_nxt   = cnt;
		slot_load = 1'b0;
		if (pe_tx_logic_clr)
		begin
			// abort from anywhere
			state_nxt = uart_tx_pkg::tx_idle;
			cnt_nxt   = 4'd0;
			slot_load = 1'b1;
		end
		else
		begin
			case (state)
				uart_tx_pkg::tx_idle:
					if (pe_tx_enable)
					begin
						state_nxt = uart_tx_pkg::tx_start;
						cnt_nxt   = 4'd0;
						slot_load = 1'b1;
					end
				uart_tx_pkg::tx_start:
					if (bit_end)
					begin
						state_nxt = uart_tx_pkg::tx_data;
						cnt_nxt   = 4'd0;
						slot_load = 1'b1;
					end
				uart_tx_pkg::tx_data:
					if (bit_end)
					begin
						slot_load = 1'b1;
						if (cnt == data_last)
						begin
							cnt_nxt = 4'd0;
							if (cfg.parity_en)
								state_nxt = uart_tx_pkg::tx_parity;
							else
								state_nxt = uart_tx_pkg::tx_stop;
						end
						else
							cnt_nxt = cnt + 4'd1;
					end
				uart_tx_pkg::tx_parity:
					if (bit_end)
					begin
						state_nxt = uart_tx_pkg::tx_stop;
						cnt_nxt   = 4'd0;
						slot_load = 1'b1;
					end
				uart_tx_pkg::tx_stop:
					if (bit_end)
					begin
						slot_load = 1'b1;
						if (cnt == stop_last)
						begin
							cnt_nxt = 4'd0;
							// interval gap only when requested
							if (cfg.interval_bit != 4'd0)
								state_nxt = uart_tx_pkg::tx_interval;
							else
								state_nxt = after_frame;
						end
						else
							cnt_nxt = cnt + 4'd1;
					end
				uart_tx_pkg::tx_interval:
					if (bit_end)
					begin
						slot_load = 1'b1;
						if (cnt == interval_last)
						begin
							cnt_nxt   = 4'd0;
							state_nxt = after_frame;
						end
						else
							cnt_nxt = cnt + 4'd1;
					end
				uart_tx_pkg::tx_end:
					// two cycles, done pulse lands in the second
					if (cnt == 4'd1)
					begin
						state_nxt = uart_tx_pkg::tx_idle;
						cnt_nxt   = 4'd0;
						slot_load = 1'b1;
					end
					else
						cnt_nxt = cnt + 4'd1;
				default:
				begin
					state_nxt = uart_tx_pkg::tx_idle;
					cnt_nxt   = 4'd0;
					slot_load = 1'b1;
				end
			endcase
		end
	end

	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
		begin
			state <= uart_tx_pkg::tx_idle;
			cnt   <= 4'd0;
		end
		else
		begin
			state <= state_nxt;
			cnt   <= cnt_nxt;
		end
	end

	// slot entered on the next edge
	assign slot.phase = state_nxt;
	assign slot.idx   = cnt_nxt;
	assign frame_end  = (state == uart_tx_pkg::tx_end);

endmodule

// ==== logic/tx_line_driver.sv ====
//==================================================
// uart tx line driver
// registers pin level and output enable from the
// announced slot, plus the transfer done pulse
//==================================================

`timescale 1ns/10ps

module tx_line_driver
(
	input  logic                   pe_clk,
	input  logic                   pe_rstn,
	input  uart_tx_pkg::tx_slot_t  slot,
	input  logic                   slot_load,
	input  uart_tx_pkg::tx_word_t  word,
	input  logic                   frame_end,
	output logic                   uart_tx,
	output logic                   uart_tx_oen,
	output logic                   tx_done
);

	//==================================================
	// pin control, idle is high and released
	//==================================================

	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
		begin
			uart_tx     <= 1'b1;
			uart_tx_oen <= 1'b1;
		end
		else if (slot_load)
		begin
			case (slot.phase)
				uart_tx_pkg::tx_start:
				begin
					uart_tx     <= 1'b0;
					uart_tx_oen <= 1'b0;
				end
				uart_tx_pkg::tx_data:
				begin
					// lsb first
					uart_tx     <= word.data[slot.idx];
					uart_tx_oen <= 1'b0;
				end
				uart_tx_pkg::tx_parity:
				begin
					uart_tx     <= word.parity;
					uart_tx_oen <= 1'b0;
				end
				uart_tx_pkg::tx_stop, uart_tx_pkg::tx_interval:
				begin
					uart_tx     <= 1'b1;
					uart_tx_oen <= 1'b0;
				end
				default:
				begin
					// idle and end release the pin
					uart_tx     <= 1'b1;
					uart_tx_oen <= 1'b1;
				end
			endcase
		end
	end

	// single pulse even though end spans two cycles
	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
			tx_done <= 1'b0;
		else
			tx_done <= frame_end && !tx_done;
	end

endmodule

// ==== logic/tx_word_loader.sv ====
//==================================================
// uart tx word loader
// one fifo read per frame, data masked to the
// configured width, parity from the masked bits
//==================================================

`timescale 1ns/10ps

module tx_word_loader
(
	input  logic                                   pe_clk,
	input  logic                                   pe_rstn,
	input  uart_tx_pkg::tx_state_e                 state,
	input  logic [uart_tx_pkg::data_max_w-1:0]     fifo_data,
	input  uart_tx_pkg::tx_frame_cfg_t             cfg,
	output logic                                   fifo_re,
	output uart_tx_pkg::tx_word_t                  word
);

	logic loaded;
	logic load_go;
	logic in_frame;
	logic [uart_tx_pkg::data_max_w-1:0] mask;
	logic parity_calc;

	// first cycle of start with nothing taken yet
	assign load_go  = (state == uart_tx_pkg::tx_start) && !loaded;
	// word is live from start through parity
	assign in_frame = state inside {uart_tx_pkg::tx_start, uart_tx_pkg::tx_data,
		uart_tx_pkg::tx_parity};

	// ones below the data width
	assign mask = ~({uart_tx_pkg::data_max_w{1'b1}} << uart_tx_pkg::data_width(cfg));

	// parity over the already masked word
	always_comb
	begin
		case (cfg.parity)
			uart_tx_pkg::parity_even:
				parity_calc = ^word.data;
			uart_tx_pkg::parity_odd:
				parity_calc = ~(^word.data);
			uart_tx_pkg::parity_space:
				parity_calc = 1'b0;
			default:
				parity_calc = 1'b1;
		endcase
	end

	//==================================================
	// fifo read strobe and loaded flag
	//==================================================

	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
		begin
			fifo_re <= 1'b0;
			loaded  <= 1'b0;
		end
		else
		begin
			fifo_re <= load_go;
			if (load_go)
				loaded <= 1'b1;
			// released in stop, or after a clear back to idle
			else if (!in_frame)
				loaded <= 1'b0;
		end
	end

	// data on the read edge, parity one cycle later
	always_ff @(posedge pe_clk)
	begin
		if (load_go)
			word.data <= fifo_data & mask;
		if (fifo_re)
			word.parity <= parity_calc;
	end

endmodule

// ==== logic/uart_pe_tx.sv ====
//==================================================
// uart tx protocol engine top
// word loader, bit timer, frame sequencer and
// line driver, widths fixed here
//==================================================

`timescale 1ns/10ps

module uart_pe_tx
#(
	parameter int clkdiv_w   = 12,
	parameter int os_w       = 4,
	parameter int fifo_lvl_w = 5
)
(
	input  logic                               pe_clk,
	input  logic                               pe_rstn,
	input  logic                               pe_tx_enable,
	input  logic                               pe_tx_logic_clr,
	input  logic [uart_tx_pkg::data_max_w-1:0] fifo_data,
	input  logic [fifo_lvl_w-1:0]              fifo_level,
	input  uart_tx_pkg::tx_frame_cfg_t         cfg,
	input  logic [clkdiv_w-1:0]                clkdiv,
	input  logic [os_w-1:0]                    oversampling,
	output logic                               fifo_re,
	output logic                               uart_tx,
	output logic                               uart_tx_oen,
	output logic                               tx_done
);

	uart_tx_pkg::tx_state_e state;
	uart_tx_pkg::tx_slot_t slot;
	uart_tx_pkg::tx_word_t word;
	logic slot_load;
	logic frame_end;
	logic bit_end;

	// bit time base
	tx_bit_timer #(
		.clkdiv_w     (clkdiv_w),
		.os_w         (os_w)
	) u_bit_timer (
		.pe_clk       (pe_clk),
		.pe_rstn      (pe_rstn),
		.state        (state),
		.clkdiv       (clkdiv),
		.oversampling (oversampling),
		.bit_end      (bit_end)
	);

	// fifo word and parity
	tx_word_loader u_word_loader (
		.pe_clk    (pe_clk),
		.pe_rstn   (pe_rstn),
		.state     (state),
		.fifo_data (fifo_data),
		.cfg       (cfg),
		.fifo_re   (fifo_re),
		.word      (word)
	);

	// frame sequencing
	tx_frame_fsm #(
		.fifo_lvl_w      (fifo_lvl_w)
	) u_frame_fsm (
		.pe_clk          (pe_clk),
		.pe_rstn         (pe_rstn),
		.pe_tx_enable    (pe_tx_enable),
		.pe_tx_logic_clr (pe_tx_logic_clr),
		.bit_end         (bit_end),
		.fifo_level      (fifo_level),
		.cfg             (cfg),
		.state           (state),
		.slot            (slot),
		.slot_load       (slot_load),
		.frame_end       (frame_end)
	);

	// pin and done pulse
	tx_line_driver u_line_driver (
		.pe_clk      (pe_clk),
		.pe_rstn     (pe_rstn),
		.slot        (slot),
		.slot_load   (slot_load),
		.word        (word),
		.frame_end   (frame_end),
		.uart_tx     (uart_tx),
		.uart_tx_oen (uart_tx_oen),
		.tx_done     (tx_done)
	);

endmodule

// ==== logic/uart_tx_pkg.sv ====
//==================================================
// uart tx protocol engine shared types
// frame format, one-hot phase encoding and the
// word and slot records passed between stages
//==================================================

package uart_tx_pkg;

	// widest data word carried by the fifo
	localparam int data_max_w = 10;

	// parity mode, space forces 0 and mark forces 1
	typedef enum logic [1:0]
	{
		parity_even  = 2'd0,
		parity_odd   = 2'd1,
		parity_space = 2'd2,
		parity_mark  = 2'd3
	} parity_e;

	// frame format, static during a transfer
	typedef struct packed
	{
		logic [3:0] data_bit;
		logic parity_en;
		parity_e parity;
		logic [1:0] stop_bit;
		logic [3:0] interval_bit;
	} tx_frame_cfg_t;

	// one-hot frame phase
	typedef enum logic [6:0]
	{
		tx_idle     = 7'b0000001,
		tx_start    = 7'b0000010,
		tx_data     = 7'b0000100,
		tx_parity   = 7'b0001000,
		tx_stop     = 7'b0010000,
		tx_interval = 7'b0100000,
		tx_end      = 7'b1000000
	} tx_state_e;

	// masked data word plus its parity bit
	typedef struct packed
	{
		logic [data_max_w-1:0] data;
		logic parity;
	} tx_word_t;

	// bit slot the line enters next
	typedef struct packed
	{
		tx_state_e phase;
		logic [3:0] idx;
	} tx_slot_t;

	// data width in use, out of range values fall back to 8
	function automatic logic [3:0] data_width(input tx_frame_cfg_t cfg);
		logic [3:0] w;
		case (cfg.data_bit)
			4'd7, 4'd8, 4'd9, 4'd10:
				w = cfg.data_bit;
			default:
				w = 4'd8;
		endcase
		return w;
	endfunction

	// stop bit count, 0 means 1
	function automatic logic [1:0] stop_width(input tx_frame_cfg_t cfg);
		return (cfg.stop_bit == 2'd0) ? 2'd1 : cfg.stop_bit;
	endfunction

endpackage

// ==== sim/uart_pe_tx_properties.sv ====
//==================================================
// uart tx protocol engine properties
// pin, read strobe and done pulse rules, bound
// to the engine top level
//==================================================

`timescale 1ns/10ps

module uart_pe_tx_properties
(
	input logic pe_clk,
	input logic pe_rstn,
	input logic pe_tx_enable,
	input logic fifo_re,
	input logic uart_tx,
	input logic uart_tx_oen,
	input logic tx_done
);

	int fail_count = 0;
	logic enabled_once;

	// set by the first enable after reset
	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
			enabled_once <= 1'b0;
		else if (pe_tx_enable)
			enabled_once <= 1'b1;
	end

	// one read per frame, never a two cycle strobe
	a_fifo_re_single: assert property (@(posedge pe_clk) disable iff (!pe_rstn)
		fifo_re |=> !fifo_re)
	else
	begin
		$error("fifo_re high for two cycles in a row");
		fail_count++;
	end

	// released pin always idles high
	a_oen_line_high: assert property (@(posedge pe_clk) disable iff (!pe_rstn)
		uart_tx_oen |-> uart_tx)
	else
	begin
		$error("uart_tx low while uart_tx_oen is high");
		fail_count++;
	end

	// done is a single cycle on a released line
	a_done_pulse: assert property (@(posedge pe_clk) disable iff (!pe_rstn)
		tx_done |-> (uart_tx && uart_tx_oen) ##1 !tx_done)
	else
	begin
		$error("tx_done longer than one cycle or line not released");
		fail_count++;
	end

	// quiet line until the first enable
	a_idle_after_reset: assert property (@(posedge pe_clk) disable iff (!pe_rstn)
		!enabled_once |-> (uart_tx && uart_tx_oen))
	else
	begin
		$error("line moved after reset before any enable");
		fail_count++;
	end

endmodule

bind uart_pe_tx uart_pe_tx_properties u_properties
(
	.pe_clk       (pe_clk),
	.pe_rstn      (pe_rstn),
	.pe_tx_enable (pe_tx_enable),
	.fifo_re      (fifo_re),
	.uart_tx      (uart_tx),
	.uart_tx_oen  (uart_tx_oen),
	.tx_done      (tx_done)
);

// ==== sim/uart_pe_tx_tb.sv ====
//==================================================
// uart tx protocol engine testbench
// show-ahead fifo model, lfsr data, frame receiver
// model and directed tests for format and abort
//==================================================

`timescale 1ns/10ps

module uart_pe_tx_tb;

	localparam int clk_div    = 3;
	localparam int os_rate    = 4;
	localparam int bit_cycles = clk_div * os_rate;
	localparam int bit_ns     = bit_cycles * 100;

	logic pe_clk;
	logic pe_rstn;
	logic pe_tx_enable;
	logic pe_tx_logic_clr;
	logic [9:0] fifo_data;
	logic [4:0] fifo_level;
	uart_tx_pkg::tx_frame_cfg_t cfg;
	logic [11:0] clkdiv;
	logic [3:0] oversampling;
	logic fifo_re;
	logic uart_tx;
	logic uart_tx_oen;
	logic tx_done;

	// fifo contents and words still owed to the receiver
	logic [9:0] fifo_q[$];
	logic [9:0] expect_q[$];
	time fall_times[$];
	logic [31:0] lfsr;
	logic pop_pending;
	int widths[3] = '{7, 9, 10};
	int errors;
	int read_count;
	int done_count;
	int frame_count;
	int abort_count;
	int tests_run;
	int tests_failed;

	uart_pe_tx #(
		.clkdiv_w        (12),
		.os_w            (4),
		.fifo_lvl_w      (5)
	) UUT (
		.pe_clk          (pe_clk),
		.pe_rstn         (pe_rstn),
		.pe_tx_enable    (pe_tx_enable),
		.pe_tx_logic_clr (pe_tx_logic_clr),
		.fifo_data       (fifo_data),
		.fifo_level      (fifo_level),
		.cfg             (cfg),
		.clkdiv          (clkdiv),
		.oversampling    (oversampling),
		.fifo_re         (fifo_re),
		.uart_tx         (uart_tx),
		.uart_tx_oen     (uart_tx_oen),
		.tx_done         (tx_done)
	);

	initial
	begin
		pe_clk = 1'b0;
		forever #50 pe_clk = ~pe_clk;
	end

	//==================================================
	// reference rules and random data
	//==================================================

	// galois form, taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// one lfsr step per bit taken
	function automatic logic [9:0] random_word();
		logic [9:0] w;
		for (int i = 0; i < 10; i++)
		begin
			w[i] = lfsr[0];
			lfsr = lfsr_step(lfsr);
		end
		return w;
	endfunction

	// 7 to 10 as given, anything else is 8
	function automatic int width_of(input uart_tx_pkg::tx_frame_cfg_t c);
		if (c.data_bit >= 4'd7 && c.data_bit <= 4'd10)
			return int'(c.data_bit);
		return 8;
	endfunction

	function automatic int stops_of(input uart_tx_pkg::tx_frame_cfg_t c);
		return (c.stop_bit == 2'd0) ? 1 : int'(c.stop_bit);
	endfunction

	// start + data + parity + stop + interval
	function automatic int frame_bits(input uart_tx_pkg::tx_frame_cfg_t c);
		return 1 + width_of(c) + int'(c.parity_en) + stops_of(c) + int'(c.interval_bit);
	endfunction

	function automatic logic parity_of(input logic [9:0] d, input uart_tx_pkg::parity_e m);
		case (m)
			uart_tx_pkg::parity_even:
				return ^d;
			uart_tx_pkg::parity_odd:
				return ~(^d);
			uart_tx_pkg::parity_space:
				return 1'b0;
			default:
				return 1'b1;
		endcase
	endfunction

	function automatic uart_tx_pkg::tx_frame_cfg_t make_cfg(input int dbit, input bit pen,
		input int mode, input int stop, input int intv);
		uart_tx_pkg::tx_frame_cfg_t c;
		c.data_bit     = 4'(dbit);
		c.parity_en    = pen;
		c.parity       = uart_tx_pkg::parity_e'(mode[1:0]);
		c.stop_bit     = 2'(stop);
		c.interval_bit = 4'(intv);
		return c;
	endfunction

	// own checks plus the bound assertion failures
	function automatic int error_total();
		return errors + UUT.u_properties.fail_count;
	endfunction

	task automatic value_mismatch(input string sig, input logic [31:0] got,
		input logic [31:0] exp);
		$display("Error: %s got %h expected %h at %0t", sig, got, exp, $time);
		errors++;
	endtask

	task automatic check_failed(input string what);
		$display("check failed: %s at %0t", what, $time);
		errors++;
	endtask

	task automatic compare_count(input string sig, input int got, input int exp);
		assert (got == exp) else value_mismatch(sig, got, exp);
	endtask

	//==================================================
	// show-ahead fifo model
	//==================================================

	task automatic fifo_refresh();
		fifo_level = 5'(fifo_q.size());
		fifo_data  = (fifo_q.size() != 0) ? fifo_q[0] : '0;
	endtask

	task automatic push_word(input logic [9:0] w);
		fifo_q.push_back(w);
		expect_q.push_back(w);
		fifo_refresh();
	endtask

	// outputs sampled mid cycle
	always @(negedge pe_clk)
	begin
		if (fifo_re)
		begin
			pop_pending = 1'b1;
			read_count++;
		end
		if (tx_done)
			done_count++;
	end

	// pop lands with the other input updates
	always @(posedge pe_clk)
	begin
		#10;
		if (pop_pending)
		begin
			if (fifo_q.size() != 0)
				void'(fifo_q.pop_front());
			else
				check_failed("fifo read while the fifo was empty");
			pop_pending = 1'b0;
			fifo_refresh();
		end
	end

	//==================================================
	// frame receiver model
	//==================================================

	task automatic sample_bit(input int delay, output logic v, output logic released);
		#(delay);
		v        = uart_tx;
		released = uart_tx_oen;
	endtask

	task automatic receive_frame();
		logic [9:0] word_exp;
		logic [9:0] data_exp;
		logic [9:0] data_got;
		logic par_exp;
		logic v;
		logic rel;
		int w;
		if (expect_q.size() == 0)
		begin
			check_failed("start bit seen with no word queued");
			return;
		end
		word_exp = expect_q.pop_front();
		w        = width_of(cfg);
		data_exp = word_exp & ((10'h1 << w) - 10'h1);
		par_exp  = parity_of(data_exp, cfg.parity);
		data_got = '0;
		fall_times.push_back($time);
		// 25 ns past mid bit keeps clear of both clock edges
		sample_bit(bit_ns / 2 + 24, v, rel);
		assert (v == 1'b0) else value_mismatch("uart_tx start bit", v, 0);
		for (int i = 0; i < w; i++)
		begin
			sample_bit(bit_ns, v, rel);
			// released mid frame, frame was aborted
			if (rel)
			begin
				abort_count++;
				return;
			end
			data_got[i] = v;
		end
		assert (data_got == data_exp) else value_mismatch("uart_tx data", data_got, data_exp);
		if (cfg.parity_en)
		begin
			sample_bit(bit_ns, v, rel);
			assert (v == par_exp) else value_mismatch("uart_tx parity bit", v, par_exp);
		end
		// stop then interval bits, all high and driven
		for (int i = 0; i < stops_of(cfg) + int'(cfg.interval_bit); i++)
		begin
			sample_bit(bit_ns, v, rel);
			assert (v == 1'b1) else value_mismatch("uart_tx stop or interval bit", v, 1);
			assert (rel == 1'b0) else value_mismatch("uart_tx_oen in stop or interval", rel, 0);
		end
		frame_count++;
	endtask

	always
	begin
		@(negedge uart_tx);
		// oen moves on the same edge as the line
		#1;
		if (pe_rstn && !uart_tx_oen)
			receive_frame();
	end

	//==================================================
	// stimulus helpers
	//==================================================

	task automatic tick();
		@(posedge pe_clk);
		#10;
	endtask

	task automatic start_tx();
		pe_tx_enable = 1'b1;
		tick();
		pe_tx_enable = 1'b0;
	endtask

	task automatic wait_done(input int limit);
		int n;
		n = 0;
		do
		begin
			@(negedge pe_clk);
			n++;
		end
		while (!tx_done && n < limit);
		if (!tx_done)
			check_failed($sformatf("no tx_done within %0d cycles", limit));
		tick();
	endtask

	task automatic line_released(input string where);
		assert (uart_tx == 1'b1) else value_mismatch({"uart_tx ", where}, uart_tx, 1);
		assert (uart_tx_oen == 1'b1) else value_mismatch({"uart_tx_oen ", where}, uart_tx_oen, 1);
	endtask

	task automatic end_test(input string name, input int err_start);
		int n;
		n = error_total() - err_start;
		tests_run++;
		if (n != 0)
			tests_failed++;
		$display("test %-20s %s (%0d errors)", name, (n == 0) ? "ok" : "FAILED", n);
	endtask

	// budget is twice the summed frame lengths
	initial
	begin : watchdog
		int bits;
		int limit;
		bits = 3 * frame_bits(make_cfg(8, 1'b0, 0, 1, 0));
		for (int m = 0; m < 4; m++)
			foreach (widths[k])
				bits += frame_bits(make_cfg(widths[k], 1'b1, m, 1, 0));
		bits += 5 * frame_bits(make_cfg(8, 1'b0, 0, 2, 3));
		limit = 2 * bits * bit_cycles;
		repeat (limit) @(posedge pe_clk);
		$display("watchdog expired after %0d cycles, tests did not finish", limit);
		$display("Regression failed");
		$finish;
	end

	//==================================================
	// test sequence
	//==================================================

	initial
	begin
		int e;
		int rd;
		int fr;
		int dn;
		int ab;
		pe_rstn         = 1'b0;
		pe_tx_enable    = 1'b0;
		pe_tx_logic_clr = 1'b0;
		cfg             = make_cfg(8, 1'b0, 0, 1, 0);
		clkdiv          = 12'(clk_div);
		oversampling    = 4'(os_rate);
		lfsr            = 32'h167e8869;
		pop_pending     = 1'b0;
		errors          = 0;
		read_count      = 0;
		done_count      = 0;
		frame_count     = 0;
		abort_count     = 0;
		tests_run       = 0;
		tests_failed    = 0;
		fifo_refresh();
		repeat (4) @(posedge pe_clk);
		#10;
		pe_rstn = 1'b1;

		// reset state, nothing moves without an enable
		e = error_total();
		repeat (20)
		begin
			@(negedge pe_clk);
			line_released("after reset");
			assert (fifo_re == 1'b0) else value_mismatch("fifo_re after reset", fifo_re, 0);
			assert (tx_done == 1'b0) else value_mismatch("tx_done after reset", tx_done, 0);
		end
		tick();
		end_test("reset state", e);

		// single 8n1 frame
		e  = error_total();
		rd = read_count;
		fr = frame_count;
		dn = done_count;
		push_word(random_word());
		start_tx();
		assert (uart_tx == 1'b0) else value_mismatch("uart_tx at start", uart_tx, 0);
		assert (uart_tx_oen == 1'b0) else value_mismatch("uart_tx_oen at start", uart_tx_oen, 0);
		wait_done(frame_bits(cfg) * bit_cycles + 20);
		line_released("after tx_done");
		repeat (4) tick();
		compare_count("fifo_re pulses", read_count - rd, 1);
		compare_count("decoded frames", frame_count - fr, 1);
		compare_count("tx_done pulses", done_count - dn, 1);
		end_test("single 8n1 frame", e);

		// every parity mode at widths 7, 9 and 10
		e = error_total();
		for (int m = 0; m < 4; m++)
			foreach (widths[k])
			begin
				cfg = make_cfg(widths[k], 1'b1, m, 1, 0);
				fr  = frame_count;
				dn  = done_count;
				push_word(random_word());
				start_tx();
				wait_done(frame_bits(cfg) * bit_cycles + 20);
				repeat (2) tick();
				compare_count("decoded frames", frame_count - fr, 1);
				compare_count("tx_done pulses", done_count - dn, 1);
			end
		end_test("widths and parity", e);

		// five words, 2 stop and 3 interval bits
		cfg = make_cfg(8, 1'b0, 0, 2, 3);
		e   = error_total();
		rd  = read_count;
		fr  = frame_count;
		dn  = done_count;
		fall_times.delete();
		for (int k = 0; k < 5; k++)
			push_word(random_word());
		start_tx();
		wait_done(5 * frame_bits(cfg) * bit_cycles + 20);
		repeat (4) tick();
		compare_count("fifo_re pulses", read_count - rd, 5);
		compare_count("decoded frames", frame_count - fr, 5);
		compare_count("tx_done pulses", done_count - dn, 1);
		// start to start covers the five bit high gap
		for (int k = 1; k < fall_times.size(); k++)
			compare_count("start bit spacing ns", int'(fall_times[k] - fall_times[k - 1]),
				frame_bits(cfg) * bit_ns);
		end_test("back to back frames", e);

		// abort in the third data bit
		cfg = make_cfg(8, 1'b0, 0, 1, 0);
		e   = error_total();
		rd  = read_count;
		fr  = frame_count;
		dn  = done_count;
		ab  = abort_count;
		push_word(random_word());
		push_word(random_word());
		start_tx();
		repeat (3 * bit_cycles) tick();
		pe_tx_logic_clr = 1'b1;
		tick();
		pe_tx_logic_clr = 1'b0;
		line_released("after logic clear");
		repeat (3 * bit_cycles) tick();
		compare_count("aborted frames", abort_count - ab, 1);
		compare_count("tx_done after clear", done_count - dn, 0);
		compare_count("fifo_re pulses", read_count - rd, 1);
		start_tx();
		wait_done(frame_bits(cfg) * bit_cycles + 20);
		repeat (4) tick();
		compare_count("decoded frames", frame_count - fr, 1);
		compare_count("tx_done pulses", done_count - dn, 1);
		compare_count("fifo_re pulses", read_count - rd, 2);
		end_test("logic clear", e);

		$display("tests %0d failed %0d errors %0d", tests_run, tests_failed, error_total());
		if (error_total() == 0 && tests_failed == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule
